/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sdram_ctrl
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/sdram_bank_tracker.sv */
/*
 * Request decode and per-bank open-row table
 * Hit and miss lookup for the current request
 */
`timescale 1ns/1ps

module sdram_bank_tracker import sdram_pkg::*; (
    input  logic                 sdram_clk,
    input  logic                 sdram_rst,
    input  logic [31:0]          adr_i,
    input  logic [DQ_WIDTH-1:0]  dat_i,
    input  logic [DQM_WIDTH-1:0] sel_i,
    input  logic                 we_i,
    input  logic                 open_i,
    input  logic                 close_i,
    input  logic                 close_all_i,
    output req_decode_t          req_o,
    output bank_hit_t            hit_o
);
    localparam int NUM_BANKS = 1 << BA_WIDTH;

    logic [NUM_BANKS-1:0] open_q;
    logic [ROW_WIDTH-1:0] row_q [NUM_BANKS];

    // Byte address, bit 0 selects the byte within a word
    always_comb begin
        req_o.ba  = adr_i[BA_WIDTH+ROW_WIDTH+COL_WIDTH:ROW_WIDTH+COL_WIDTH+1];
        req_o.row = adr_i[ROW_WIDTH+COL_WIDTH:COL_WIDTH+1];
        req_o.col = adr_i[COL_WIDTH+1:1];
        req_o.we  = we_i;
        req_o.sel = sel_i;
        req_o.dat = dat_i;
    end

    always_comb begin
        hit_o.bank_open = open_q[req_o.ba];
        hit_o.row_hit   = open_q[req_o.ba] && (row_q[req_o.ba] == req_o.row);
        hit_o.any_open  = |open_q;
    end

    always_ff @(posedge sdram_clk) begin
        if (sdram_rst) begin
            open_q <= '0;
        end else if (close_all_i) begin
            open_q <= '0;
        end else if (close_i) begin
            open_q[req_o.ba] <= 1'b0;
        end else if (open_i) begin
            open_q[req_o.ba] <= 1'b1;
        end
    end

    always_ff @(posedge sdram_clk) begin
        if (open_i)
            row_q[req_o.ba] <= req_o.row;
    end

endmodule

/* hdl/sdram_cmd_issue.sv */
/*
 * Pin issue register
 * Command, address, bank, data and mask outputs, response flags
 */
`timescale 1ns/1ps

module sdram_cmd_issue import sdram_pkg::*; (
    input  logic                 sdram_clk,
    input  logic                 sdram_rst,
    input  sdram_cmd_t           cmd_i,
    input  logic [31:0]          adr_i,
    output logic [BA_WIDTH-1:0]  ba_o,
    output logic [A_WIDTH-1:0]   a_o,
    output logic                 ras_n_o,
    output logic                 cas_n_o,
    output logic                 we_n_o,
    output logic [DQ_WIDTH-1:0]  dq_o,
    output logic [DQM_WIDTH-1:0] dqm_o,
    output logic                 dq_oe_o,
    output logic                 wr_ack_o,
    output logic                 rd_start_o,
    output logic [31:0]          rd_adr_o
);
    logic [4:0]         code;
    logic [A_WIDTH-1:0] a_word;

    assign code = cmd_i.cmd;

    always_comb begin
        a_word = cmd_i.addr.word;
        if (code[4])
            a_word[10] = code[3];  // Precharge scope bit
    end

    always_ff @(posedge sdram_clk) begin
        if (sdram_rst) begin
            {ras_n_o, cas_n_o, we_n_o} <= 3'b111;
            dqm_o      <= '1;
            dq_oe_o    <= 1'b0;
            wr_ack_o   <= 1'b0;
            rd_start_o <= 1'b0;
        end else begin
            {ras_n_o, cas_n_o, we_n_o} <= code[2:0];
            dqm_o      <= cmd_i.dqm;
            dq_oe_o    <= cmd_i.dq_oe;
            wr_ack_o   <= cmd_i.wr_ack;
            rd_start_o <= cmd_i.rd_start;
        end
    end

    always_ff @(posedge sdram_clk) begin
        ba_o <= cmd_i.ba;
        a_o  <= a_word;
        dq_o <= cmd_i.dq;
        if (cmd_i.rd_start || cmd_i.wr_ack)
            rd_adr_o <= adr_i;  // Held for the response stage
    end

endmodule

/* hdl/sdram_ctrl.sv */
/*
 * SDR SDRAM controller top level
 * Lookup, init, sequencer, issue and response stages
 */
`timescale 1ns/1ps

module sdram_ctrl import sdram_pkg::*; #(
    parameter int POWERUP_CYCLES = 20000,
    parameter int REFRESH_CYCLES = 780,
    parameter int BURST_LEN      = 4,
    parameter int CAS_LAT        = 2,
    parameter int T_RP           = 2,
    parameter int T_RC           = 7,
    parameter int T_RCD          = 3,
    parameter int T_MRD          = 2
) (
    input  logic                 sdram_clk,
    input  logic                 sdram_rst,
    output logic [BA_WIDTH-1:0]  ba_o,
    output logic [A_WIDTH-1:0]   a_o,
    output logic                 ras_n_o,
    output logic                 cas_n_o,
    output logic                 we_n_o,
    output logic [DQ_WIDTH-1:0]  dq_o,
    output logic [DQM_WIDTH-1:0] dqm_o,
    input  logic [DQ_WIDTH-1:0]  dq_i,
    output logic                 dq_oe_o,
    output logic                 idle_o,
    input  logic [31:0]          adr_i,
    output logic [31:0]          adr_o,
    input  logic [DQ_WIDTH-1:0]  dat_i,
    output logic [DQ_WIDTH-1:0]  dat_o,
    input  logic [DQM_WIDTH-1:0] sel_i,
    input  logic                 acc_i,
    output logic                 ack_o,
    input  logic                 we_i
);
    req_decode_t req;
    bank_hit_t   hit;
    sdram_cmd_t  init_cmd;
    sdram_cmd_t  seq_cmd;
    logic        init_done;
    logic        bank_open;
    logic        bank_close;
    logic        bank_close_all;
    logic        wr_ack;
    logic        rd_start;
    logic [31:0] rd_adr;

    sdram_bank_tracker tracker_i (
        .sdram_clk, .sdram_rst, .adr_i, .dat_i, .sel_i, .we_i,
        .open_i(bank_open), .close_i(bank_close), .close_all_i(bank_close_all),
        .req_o(req), .hit_o(hit)
    );

    sdram_init_seq #(
        .POWERUP_CYCLES(POWERUP_CYCLES), .T_RP(T_RP), .T_RC(T_RC),
        .T_MRD(T_MRD), .CAS_LAT(CAS_LAT), .BURST_LEN(BURST_LEN)
    ) init_i (
        .sdram_clk, .sdram_rst, .cmd_o(init_cmd), .done_o(init_done)
    );

    sdram_sequencer #(
        .REFRESH_CYCLES(REFRESH_CYCLES), .BURST_LEN(BURST_LEN), .CAS_LAT(CAS_LAT),
        .T_RP(T_RP), .T_RC(T_RC), .T_RCD(T_RCD)
    ) seq_i (
        .sdram_clk, .sdram_rst, .acc_i, .req_i(req), .hit_i(hit),
        .init_cmd_i(init_cmd), .init_done_i(init_done), .cmd_o(seq_cmd),
        .open_o(bank_open), .close_o(bank_close), .close_all_o(bank_close_all), .idle_o
    );

    sdram_cmd_issue issue_i (
        .sdram_clk, .sdram_rst, .cmd_i(seq_cmd), .adr_i,
        .ba_o, .a_o, .ras_n_o, .cas_n_o, .we_n_o, .dq_o, .dqm_o, .dq_oe_o,
        .wr_ack_o(wr_ack), .rd_start_o(rd_start), .rd_adr_o(rd_adr)
    );

    sdram_response #(.CAS_LAT(CAS_LAT), .BURST_LEN(BURST_LEN)) response_i (
        .sdram_clk, .sdram_rst, .wr_ack_i(wr_ack), .rd_start_i(rd_start),
        .rd_adr_i(rd_adr), .dq_i, .ack_o, .dat_o, .adr_o
    );

endmodule

/* hdl/sdram_init_seq.sv */
/*
 * Power-up initialisation sequence
 * Wait, precharge-all, eight auto-refreshes, mode-register set
 */
`timescale 1ns/1ps

module sdram_init_seq import sdram_pkg::*; #(
    parameter int POWERUP_CYCLES = 20000,
    parameter int T_RP           = 2,
    parameter int T_RC           = 7,
    parameter int T_MRD          = 2,
    parameter int CAS_LAT        = 2,
    parameter int BURST_LEN      = 4
) (
    input  logic       sdram_clk,
    input  logic       sdram_rst,
    output sdram_cmd_t cmd_o,
    output logic       done_o
);
    localparam int CW = $clog2(POWERUP_CYCLES + T_RP + T_RC + T_MRD + 1);

    typedef enum logic [2:0] {I_POWERUP, I_PALL, I_REF, I_MRS, I_DONE} init_state_e;

    init_state_e   state;
    logic [CW-1:0] cnt;
    logic [CW-1:0] limit;
    logic [2:0]    ref_cnt;
    logic          step;
    mode_reg_t     mode_word;

    always_comb begin
        case (state)
            I_POWERUP: limit = CW'(POWERUP_CYCLES - 1);
            I_PALL:    limit = CW'(T_RP - 1);
            I_REF:     limit = CW'(T_RC - 1);
            I_MRS:     limit = CW'(T_MRD - 1);
            default:   limit = '0;
        endcase
    end

    assign step   = (state != I_DONE) && (cnt == limit);
    assign done_o = (state == I_DONE);

    always_ff @(posedge sdram_clk) begin
        if (sdram_rst) begin
            state   <= I_POWERUP;
            cnt     <= '0;
            ref_cnt <= '0;
        end else if (step) begin
            cnt <= '0;
            case (state)
                I_POWERUP: state <= I_PALL;
                I_PALL:    state <= I_REF;
                I_REF: begin
                    if (ref_cnt == 3'd7)
                        state <= I_MRS;
                    ref_cnt <= ref_cnt + 3'd1;
                end
                default:   state <= I_DONE;
            endcase
        end else if (state != I_DONE) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_comb begin
        mode_word           = '0;
        mode_word.wb_single = 1'b1;
        mode_word.cas_lat   = 3'(CAS_LAT);
        mode_word.burst_len = burst_code(BURST_LEN);
    end

    // Command fires on the cycle a wait expires
    always_comb begin
        cmd_o           = '0;
        cmd_o.cmd       = CMD_NOP;
        cmd_o.dqm       = '1;
        cmd_o.addr.mode = mode_word;
        if (step) begin
            case (state)
                I_POWERUP: cmd_o.cmd = CMD_PALL;
                I_PALL:    cmd_o.cmd = CMD_REF;   // First of eight
                I_REF:     cmd_o.cmd = (ref_cnt == 3'd7) ? CMD_MRS : CMD_REF;
                default:   cmd_o.cmd = CMD_NOP;
            endcase
        end
    end

endmodule

/* hdl/sdram_pkg.sv */
/*
 * SDRAM controller shared definitions
 * Geometry widths, command encodings, mode-register layout,
 * request, lookup and command structs, burst-length code function
 */
package sdram_pkg;

    localparam int BA_WIDTH  = 2;
    localparam int ROW_WIDTH = 13;
    localparam int COL_WIDTH = 9;
    localparam int A_WIDTH   = 13;
    localparam int DQ_WIDTH  = 16;
    localparam int DQM_WIDTH = 2;

    // Bit order is a10 drive, a10 value, ras_n, cas_n, we_n
    typedef enum logic [4:0] {
        CMD_NOP   = 5'b10111,
        CMD_READ  = 5'b10101,
        CMD_WRITE = 5'b10100,
        CMD_ACT   = 5'b00011,
        CMD_PRE   = 5'b10010,
        CMD_PALL  = 5'b11010,  // a10 high selects all banks
        CMD_REF   = 5'b00001,
        CMD_MRS   = 5'b10000
    } sdram_cmd_e;

    typedef struct packed {
        logic [2:0] reserved;
        logic       wb_single;   // Writes are single location
        logic [1:0] op_mode;     // Standard operation is 0
        logic [2:0] cas_lat;
        logic       burst_type;  // Sequential is 0
        logic [2:0] burst_len;
    } mode_reg_t;

    // Same pins carry either the mode word or a row/column address
    typedef union packed {
        mode_reg_t          mode;
        logic [A_WIDTH-1:0] word;
    } sdram_addr_u;

    typedef struct packed {
        logic [BA_WIDTH-1:0]  ba;
        logic [ROW_WIDTH-1:0] row;
        logic [COL_WIDTH:0]   col;  // Word address, top bit ignored by the device
        logic                 we;
        logic [DQM_WIDTH-1:0] sel;
        logic [DQ_WIDTH-1:0]  dat;
    } req_decode_t;

    typedef struct packed {
        logic bank_open;
        logic row_hit;
        logic any_open;  // Some bank needs closing before refresh
    } bank_hit_t;

    typedef struct packed {
        sdram_cmd_e           cmd;
        logic [BA_WIDTH-1:0]  ba;
        sdram_addr_u          addr;
        logic [DQ_WIDTH-1:0]  dq;
        logic [DQM_WIDTH-1:0] dqm;
        logic                 dq_oe;
        logic                 wr_ack;
        logic                 rd_start;
    } sdram_cmd_t;

    function automatic logic [2:0] burst_code(input int len);
        case (len)
            2:       return 3'b001;
            4:       return 3'b010;
            8:       return 3'b011;
            default: return 3'b000;  // Single word
        endcase
    endfunction

endpackage

/* hdl/sdram_response.sv */
/*
 * Response capture
 * Write acknowledge, CAS latency count, read data and burst address
 */
`timescale 1ns/1ps

module sdram_response import sdram_pkg::*; #(
    parameter int CAS_LAT   = 2,
    parameter int BURST_LEN = 4
) (
    input  logic                sdram_clk,
    input  logic                sdram_rst,
    input  logic                wr_ack_i,
    input  logic                rd_start_i,
    input  logic [31:0]         rd_adr_i,
    input  logic [DQ_WIDTH-1:0] dq_i,
    output logic                ack_o,
    output logic [DQ_WIDTH-1:0] dat_o,
    output logic [31:0]         adr_o
);
    localparam int          LAST      = CAS_LAT + BURST_LEN - 2;
    localparam int          CW        = $clog2(LAST + 2);
    localparam logic [31:0] STEP_MASK = 32'((BURST_LEN - 1) << 1);  // Word bits inside a burst

    logic          busy;
    logic          active;
    logic          capture;
    logic          first;
    logic          rd_ack;
    logic [CW-1:0] cnt;
    logic [CW-1:0] cur;
    logic [31:0]   adr_q;

    // Edges since the READ reached the pins, less one
    assign cur     = rd_start_i ? '0 : cnt;
    assign active  = rd_start_i || busy;
    assign first   = active && (cur == CW'(CAS_LAT - 1));
    assign capture = active && (cur >= CW'(CAS_LAT - 1));

    always_ff @(posedge sdram_clk) begin
        if (sdram_rst) begin
            busy   <= 1'b0;
            cnt    <= '0;
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= first;
            if (active) begin
                cnt  <= cur + 1'b1;
                busy <= (cur != CW'(LAST));
            end
        end
    end

    always_ff @(posedge sdram_clk) begin
        if (capture)
            dat_o <= dq_i;
        if (first)
            adr_q <= rd_adr_i;
        else if (capture)
            adr_q <= (adr_q & ~STEP_MASK) | ((adr_q + 32'd2) & STEP_MASK);  // Wraps in burst
    end

    assign ack_o = rd_ack || wr_ack_i;
    assign adr_o = wr_ack_i ? rd_adr_i : adr_q;

endmodule

/* hdl/sdram_sequencer.sv */
/*
 * Main command sequencer
 * Refresh scheduling, row hit and miss handling, read and write states
 */
`timescale 1ns/1ps

module sdram_sequencer import sdram_pkg::*; #(
    parameter int REFRESH_CYCLES = 780,
    parameter int BURST_LEN      = 4,
    parameter int CAS_LAT        = 2,
    parameter int T_RP           = 2,
    parameter int T_RC           = 7,
    parameter int T_RCD          = 3
) (
    input  logic        sdram_clk,
    input  logic        sdram_rst,
    input  logic        acc_i,
    input  req_decode_t req_i,
    input  bank_hit_t   hit_i,
    input  sdram_cmd_t  init_cmd_i,
    input  logic        init_done_i,
    output sdram_cmd_t  cmd_o,
    output logic        open_o,
    output logic        close_o,
    output logic        close_all_o,
    output logic        idle_o
);
    localparam int SC_W = $clog2(CAS_LAT + BURST_LEN + T_RP + T_RC + T_RCD + 1);
    localparam int RC_W = $clog2(REFRESH_CYCLES + 1);

    typedef enum logic [2:0] {
        S_IDLE, S_REFRESH, S_PALL, S_PRE, S_ACT, S_READ, S_WRITE
    } seq_state_e;

    seq_state_e      state;
    seq_state_e      state_nxt;
    logic [SC_W-1:0] cnt;
    logic [RC_W-1:0] ref_cnt;
    logic            refresh_due;
    logic            first;
    logic            we_r;

    assign refresh_due = (ref_cnt == RC_W'(REFRESH_CYCLES));
    assign first       = (cnt == '0);
    assign idle_o      = init_done_i &&
                         (state == S_IDLE || state == S_PALL || state == S_REFRESH);

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (!init_done_i)
                    state_nxt = S_IDLE;
                else if (refresh_due)
                    state_nxt = hit_i.any_open ? S_PALL : S_REFRESH;
                else if (acc_i && hit_i.row_hit)
                    state_nxt = req_i.we ? S_WRITE : S_READ;
                else if (acc_i)
                    state_nxt = hit_i.bank_open ? S_PRE : S_ACT;
            end
            S_PALL:    if (cnt == SC_W'(T_RP - 1)) state_nxt = S_REFRESH;
            S_REFRESH: if (cnt == SC_W'(T_RC - 1)) state_nxt = S_IDLE;
            S_PRE:     if (cnt == SC_W'(T_RP - 1)) state_nxt = S_ACT;
            S_ACT:     if (cnt == SC_W'(T_RCD - 1)) state_nxt = we_r ? S_WRITE : S_READ;
            S_READ:    if (cnt == SC_W'(CAS_LAT + BURST_LEN)) state_nxt = S_IDLE;
            default:   state_nxt = S_IDLE;  // Write takes one cycle
        endcase
    end

    always_ff @(posedge sdram_clk) begin
        if (sdram_rst) begin
            state   <= S_IDLE;
            cnt     <= '0;
            ref_cnt <= '0;
            we_r    <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state_nxt != state || state == S_IDLE)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;

            if (!init_done_i || (state == S_IDLE && refresh_due))
                ref_cnt <= '0;
            else if (!refresh_due)
                ref_cnt <= ref_cnt + 1'b1;

            if (state == S_IDLE)
                we_r <= req_i.we;  // Kept across PRE and ACT
        end
    end

    always_comb begin
        cmd_o           = '0;
        cmd_o.cmd       = CMD_NOP;
        cmd_o.ba        = req_i.ba;
        cmd_o.addr.word = A_WIDTH'(req_i.col);
        cmd_o.dq        = req_i.dat;
        cmd_o.dqm       = '1;
        open_o          = 1'b0;
        close_o         = 1'b0;
        close_all_o     = 1'b0;
        if (!init_done_i) begin
            cmd_o = init_cmd_i;
        end else begin
            case (state)
                S_PALL: begin
                    cmd_o.cmd   = first ? CMD_PALL : CMD_NOP;
                    close_all_o = first;
                end
                S_REFRESH: cmd_o.cmd = first ? CMD_REF : CMD_NOP;
                S_PRE: begin
                    cmd_o.cmd = first ? CMD_PRE : CMD_NOP;
                    close_o   = first;
                end
                S_ACT: begin
                    cmd_o.cmd       = first ? CMD_ACT : CMD_NOP;
                    cmd_o.addr.word = req_i.row;
                    open_o          = first;
                end
                S_READ: begin
                    cmd_o.cmd      = first ? CMD_READ : CMD_NOP;
                    cmd_o.dqm      = '0;  // Burst stays unmasked
                    cmd_o.rd_start = first;
                end
                S_WRITE: begin
                    cmd_o.cmd    = CMD_WRITE;
                    cmd_o.dqm    = ~req_i.sel;
                    cmd_o.dq_oe  = 1'b1;
                    cmd_o.wr_ack = 1'b1;
                end
                default: cmd_o.cmd = CMD_NOP;
            endcase
        end
    end

endmodule

/* tests/sdram_ctrl_properties.sv */
/*
 * Command timing assertions, bound into the controller top level
 */
`timescale 1ns/1ps

module sdram_ctrl_properties import sdram_pkg::*; #(
    parameter int T_RP = 2
) (
    input logic                sdram_clk,
    input logic                sdram_rst,
    input logic [BA_WIDTH-1:0] ba_i,
    input logic [A_WIDTH-1:0]  a_i,
    input logic                ras_n_i,
    input logic                cas_n_i,
    input logic                we_n_i,
    input logic                ack_i
);
    logic [(1<<BA_WIDTH)-1:0] bank_act;
    int unsigned              since_pre;
    int unsigned              fail_cnt = 0;  // Failed assertion count
    logic                     is_act;
    logic                     is_rw;
    logic                     is_write;
    logic                     is_pre;
    logic                     is_pall;

    assign is_act   = ({ras_n_i, cas_n_i, we_n_i} == 3'b011);
    assign is_write = ({ras_n_i, cas_n_i, we_n_i} == 3'b100);
    assign is_rw    = is_write || ({ras_n_i, cas_n_i, we_n_i} == 3'b101);
    assign is_pre   = ({ras_n_i, cas_n_i, we_n_i} == 3'b010) && !a_i[10];
    assign is_pall  = ({ras_n_i, cas_n_i, we_n_i} == 3'b010) && a_i[10];

    // Banks activated since their last precharge
    always_ff @(posedge sdram_clk) begin
        if (sdram_rst) begin
            bank_act  <= '0;
            since_pre <= T_RP;
        end else begin
            if (is_pall)
                bank_act <= '0;
            else if (is_pre)
                bank_act[ba_i] <= 1'b0;
            else if (is_act)
                bank_act[ba_i] <= 1'b1;
            if (is_pre || is_pall)
                since_pre <= 1;
            else if (since_pre < T_RP)
                since_pre <= since_pre + 1;
        end
    end

    rw_after_act: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
        is_rw |-> bank_act[ba_i])
        else begin
            fail_cnt++;
            $error("READ or WRITE to a bank that is not active");
        end

    act_after_trp: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
        is_act |-> since_pre >= T_RP)
        else begin
            fail_cnt++;
            $error("ACT issued before tRP elapsed");
        end

    write_ack_single: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
        (is_write && ack_i) |=> !ack_i)
        else begin
            fail_cnt++;
            $error("write ack held for more than one cycle");
        end

endmodule

bind sdram_ctrl sdram_ctrl_properties #(.T_RP(T_RP)) props_i (
    .sdram_clk(sdram_clk), .sdram_rst(sdram_rst), .ba_i(ba_o), .a_i(a_o),
    .ras_n_i(ras_n_o), .cas_n_i(cas_n_o), .we_n_i(we_n_o), .ack_i(ack_o)
);

/* tests/tb_clock_gen.sv */
/*
 * Testbench clock and power-on reset
 */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;  // 10 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

/* tests/tb_sdram_ctrl.sv */
/*
 * SDRAM controller testbench
 * Behavioural SDRAM model, random requester, reference memory and checks
 */
`timescale 1ns/1ps

module tb_sdram_ctrl import sdram_pkg::*; ();
    localparam int POWERUP = 50;
    localparam int REFRESH = 100;
    localparam int BL      = 4;
    localparam int CL      = 2;
    localparam int N_ACC   = 200;
    localparam int SLACK   = 40;  // Longest access that can delay a refresh

    typedef enum logic [3:0] {
        P_NOP, P_ACT, P_READ, P_WRITE, P_PRE, P_PALL, P_REF, P_MRS, P_OTHER
    } pin_cmd_e;

    logic                 sdram_clk, sdram_rst;
    logic [BA_WIDTH-1:0]  ba_o;
    logic [A_WIDTH-1:0]   a_o;
    logic                 ras_n_o, cas_n_o, we_n_o, dq_oe_o, idle_o, ack_o;
    logic [DQ_WIDTH-1:0]  dq_o, dq_i, dat_i, dat_o;
    logic [DQM_WIDTH-1:0] dqm_o, sel_i;
    logic [31:0]          adr_i, adr_o;
    logic                 acc_i, we_i;

    logic [15:0] dev_mem [int];
    logic [15:0] ref_mem [int];
    logic [15:0] rd_sched [int];  // Read data keyed by cycle
    logic        row_open [4];
    logic [12:0] row_of [4];
    pin_cmd_e    init_cmds [$];
    logic [12:0] mrs_word;
    int          cyc = 0;
    int          last_ref = 0;
    int          n_pre = 0, n_act = 0, n_pall = 0, n_ref = 0;
    bit          init_seen = 0;

    tb_clock_gen #(.RESET_CYCLES(8)) clk_gen_i (.clk_o(sdram_clk), .rst_o(sdram_rst));

    sdram_ctrl #(
        .POWERUP_CYCLES(POWERUP), .REFRESH_CYCLES(REFRESH), .BURST_LEN(BL), .CAS_LAT(CL),
        .T_RP(2), .T_RC(7), .T_RCD(3), .T_MRD(2)
    ) dut_i (.*);

    task automatic fail_run(input string what);
        $display("Error at %0t: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "check mismatch");
        end
    endtask

    // Unwritten words read back a pattern of their own address
    function automatic logic [15:0] fill_word(input logic [23:0] key);
        return key[15:0] ^ {8'h3c, key[23:16]};
    endfunction

    function automatic logic [15:0] dev_read(input logic [23:0] key);
        return dev_mem.exists(key) ? dev_mem[key] : fill_word(key);
    endfunction

    function automatic logic [15:0] ref_read(input logic [23:0] key);
        return ref_mem.exists(key) ? ref_mem[key] : fill_word(key);
    endfunction

    function automatic pin_cmd_e decode_pins(input logic [2:0] rcw, input logic a10);
        case (rcw)
            3'b111:  return P_NOP;
            3'b011:  return P_ACT;
            3'b101:  return P_READ;
            3'b100:  return P_WRITE;
            3'b010:  return a10 ? P_PALL : P_PRE;
            3'b001:  return P_REF;
            3'b000:  return P_MRS;
            default: return P_OTHER;
        endcase
    endfunction

    task automatic observe_pins();
        pin_cmd_e    c;
        logic [23:0] key;
        logic [15:0] w;
        logic [8:0]  col;
        c = decode_pins({ras_n_o, cas_n_o, we_n_o}, a_o[10]);
        check_eq(dq_oe_o, c == P_WRITE, "dq_oe_o against command");  // Bus driven only on WRITE
        if (!init_seen && c != P_NOP) begin
            init_cmds.push_back(c);
            if (c == P_MRS)
                mrs_word = a_o;
        end
        case (c)
            P_ACT: begin
                row_open[ba_o] = 1'b1;
                row_of[ba_o]   = a_o;
                n_act++;
            end
            P_PRE: begin
                row_open[ba_o] = 1'b0;
                n_pre++;
            end
            P_PALL: begin
                foreach (row_open[b]) row_open[b] = 1'b0;
                n_pall++;
            end
            P_REF: begin
                if (init_seen) begin
                    foreach (row_open[b]) check_eq(row_open[b], 1'b0, "bank open at REF");
                    last_ref = cyc;
                    n_ref++;
                end
            end
            P_WRITE: begin
                key = {ba_o, row_of[ba_o], a_o[8:0]};
                w   = dev_read(key);
                if (!dqm_o[0]) w[7:0] = dq_o[7:0];
                if (!dqm_o[1]) w[15:8] = dq_o[15:8];
                dev_mem[key] = w;
            end
            P_READ: begin
                for (int k = 0; k < BL; k++) begin
                    col = (a_o[8:0] & ~9'(BL - 1)) | ((a_o[8:0] + 9'(k)) & 9'(BL - 1));
                    rd_sched[cyc + CL - 1 + k] = dev_read({ba_o, row_of[ba_o], col});
                end
            end
            default: ;
        endcase
        if (idle_o && !init_seen) begin
            init_seen = 1;
            last_ref  = cyc;
        end
    endtask

    // One falling edge: observe the pins, then drive the data bus
    task automatic step();
        @(negedge sdram_clk);
        cyc++;
        observe_pins();
        if (rd_sched.exists(cyc)) begin
            dq_i = rd_sched[cyc];
            rd_sched.delete(cyc);
        end else begin
            dq_i = '0;
        end
        if (init_seen && cyc - last_ref > REFRESH + SLACK)
            fail_run("no auto-refresh within the refresh interval");
    endtask

    task automatic do_access(input logic wr, input logic [31:0] a,
                             input logic [15:0] d, input logic [1:0] s);
        logic [1:0]  bank;
        logic [12:0] row;
        logic [15:0] w;
        logic [31:0] exp_adr;
        logic [30:0] wd;
        int          pos;
        int          pre0, act0, pall0, t;
        bit          exp_pre, exp_act;
        bank      = a[24:23];
        row       = a[22:10];
        exp_act   = !(row_open[bank] && row_of[bank] == row);
        exp_pre   = row_open[bank] && row_of[bank] != row;
        pre0  = n_pre;
        act0  = n_act;
        pall0 = n_pall;
        adr_i = a;
        dat_i = d;
        sel_i = s;
        we_i  = wr;
        acc_i = 1'b1;
        t = 0;
        do begin
            step();
            t++;
            if (t > 200)
                fail_run("ack_o never came for an access");
        end while (!ack_o);
        acc_i = 1'b0;
        check_eq(adr_o, a, "adr_o on ack");
        if (n_pall != pall0) begin  // Refresh closed every bank first
            exp_pre = 0;
            exp_act = 1;
        end
        check_eq(n_pre - pre0, exp_pre, "PRE count for access");
        check_eq(n_act - act0, exp_act, "ACT count for access");
        if (wr) begin
            w = ref_read(a[24:1]);
            if (s[0]) w[7:0] = d[7:0];
            if (s[1]) w[15:8] = d[15:8];
            ref_mem[a[24:1]] = w;
        end else begin
            wd  = a[31:1];
            pos = int'(wd % BL);  // Word position inside its burst
            for (int k = 0; k < BL; k++) begin
                if (k > 0)
                    step();
                exp_adr = {wd - 31'(pos) + 31'((pos + k) % BL), a[0]};
                check_eq(adr_o, exp_adr, "burst adr_o");
                check_eq(dat_o, ref_read(exp_adr[24:1]), "burst read data");
            end
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [12:0] exp_mode;
        int          t;
        int          ref0;
        adr_i = '0;
        dat_i = '0;
        sel_i = '0;
        acc_i = 1'b0;
        we_i  = 1'b0;
        dq_i  = '0;
        foreach (row_open[b]) row_open[b] = 1'b0;
        void'($urandom(32'h9cf4));

        t = 0;
        while (!init_seen) begin
            step();
            t++;
            if (t > 2000)
                fail_run("idle_o never rose after power-up");
        end
        check_eq(init_cmds.size(), 10, "init command count");
        check_eq(init_cmds[0], P_PALL, "first init command");
        for (int i = 1; i <= 8; i++)
            check_eq(init_cmds[i], P_REF, "init refresh");
        check_eq(init_cmds[9], P_MRS, "last init command");
        exp_mode = {3'b000, 1'b1, 2'b00, 3'(CL), 1'b0, 3'($clog2(BL))};
        check_eq(mrs_word, exp_mode, "MRS mode word");

        for (int i = 0; i < N_ACC; i++) begin
            a = (32'($urandom_range(0, 3)) << 23) | (32'($urandom_range(0, 2)) << 10) |
                (32'($urandom_range(0, 15)) << 1);
            do_access(1'($urandom_range(0, 1)), a, 16'($urandom), 2'($urandom_range(1, 3)));
        end

        ref0 = n_ref;
        repeat (3 * REFRESH) step();
        if (n_ref - ref0 < 2)
            fail_run("too few refreshes while the bus was idle");

        if (dut_i.props_i.fail_cnt != 0) begin
            fail_run("a bound command timing assertion failed");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

/* verilog.f */
hdl/sdram_pkg.sv
hdl/sdram_bank_tracker.sv
hdl/sdram_init_seq.sv
hdl/sdram_sequencer.sv
hdl/sdram_cmd_issue.sv
hdl/sdram_response.sv
hdl/sdram_ctrl.sv
tests/tb_clock_gen.sv
tests/sdram_ctrl_properties.sv
tests/tb_sdram_ctrl.sv
